// File: rtl/mipsCore_consts.svh
`ifndef MIPS_CORE_CONSTS_SVH
`define MIPS_CORE_CONSTS_SVH

// First instruction fetched after reset
`define RESET_VECTOR 32'hBFC00000

// General purpose register file size
`define NUM_REGS 32

// Register observed at the top level (v0)
`define V0_INDEX 5'd2

// Register written by JAL
`define RA_INDEX 5'd31

`endif

// File: rtl/mipsIsaPkg.sv
package mipsIsaPkg;

	// Instruction field widths
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm16_t;
	typedef logic [25:0] instrIndex_t;

	// Primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTIU   = 6'h0B,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_XORI    = 6'h0E,
		OP_LUI     = 6'h0F,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcode_e;

	// Function codes of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} funct_e;

endpackage

// File: rtl/mipsCorePkg.sv
package mipsCorePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_LUI  = 4'd9
	} aluOp_e;

	// Per-instruction control word from the decoder
	typedef struct packed {
		aluOp_e aluOp;
		logic useImm;
		logic regWrite;
		regIdx_t writeReg;
		logic memRead;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic jump;
		logic jumpReg;
		logic link;
		mipsIsaPkg::shamt_t shamt;
	} ctrl_t;

	typedef struct packed {
		word_t value;
		logic eq;
	} aluRes_t;

endpackage

// File: rtl/controlDecoder.sv
`timescale 1ns/100ps
`include "mipsCore_consts.svh"

module controlDecoder (
	input mipsCorePkg::word_t instr,
	output mipsCorePkg::ctrl_t ctrl,
	output mipsCorePkg::word_t immOperand
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	opcode_e opcode;
	funct_e funct;
	word_t signExt;
	word_t zeroExt;
	logic supported;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct = funct_e'(instr[5:0]);
	assign signExt = {{16{instr[15]}}, instr[15:0]};
	assign zeroExt = {16'h0000, instr[15:0]};

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = ALU_ADD;
		ctrl.writeReg = instr[20:16];
		ctrl.shamt = instr[10:6];
		immOperand = signExt;
		supported = 1'b1;
		case (opcode)
			OP_SPECIAL: begin
				// R-type writes rd
				ctrl.writeReg = instr[15:11];
				ctrl.regWrite = 1'b1;
				case (funct)
					FN_ADDU: ctrl.aluOp = ALU_ADD;
					FN_SUBU: ctrl.aluOp = ALU_SUB;
					FN_AND:  ctrl.aluOp = ALU_AND;
					FN_OR:   ctrl.aluOp = ALU_OR;
					FN_XOR:  ctrl.aluOp = ALU_XOR;
					FN_SLT:  ctrl.aluOp = ALU_SLT;
					FN_SLTU: ctrl.aluOp = ALU_SLTU;
					FN_SLL:  ctrl.aluOp = ALU_SLL;
					FN_SRL:  ctrl.aluOp = ALU_SRL;
					FN_JR: begin
						ctrl.regWrite = 1'b0;
						ctrl.jumpReg = 1'b1;
					end
					default: begin
						ctrl.regWrite = 1'b0;
						supported = 1'b0;
					end
				endcase
			end
			OP_ADDIU: {ctrl.useImm, ctrl.regWrite} = 2'b11;
			OP_SLTIU: begin
				{ctrl.useImm, ctrl.regWrite} = 2'b11;
				ctrl.aluOp = ALU_SLTU;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				{ctrl.useImm, ctrl.regWrite} = 2'b11;
				immOperand = zeroExt;
				ctrl.aluOp = (opcode == OP_ANDI) ? ALU_AND :
					(opcode == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_LUI: begin
				{ctrl.useImm, ctrl.regWrite} = 2'b11;
				ctrl.aluOp = ALU_LUI;
				immOperand = {instr[15:0], 16'h0000};
			end
			OP_LW: {ctrl.useImm, ctrl.regWrite, ctrl.memRead} = 3'b111;
			OP_SW: {ctrl.useImm, ctrl.memWrite} = 2'b11;
			OP_BEQ: ctrl.branchEq = 1'b1;
			OP_BNE: ctrl.branchNe = 1'b1;
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				{ctrl.jump, ctrl.link, ctrl.regWrite} = 3'b111;
				ctrl.writeReg = `RA_INDEX;
			end
			default: supported = 1'b0;
		endcase
	end

	// Fetched word must be part of the supported subset once memory drives it
	always_comb begin
		if (!$isunknown(instr)) begin
			assert (supported)
				else $error("controlDecoder: unsupported instruction %h", instr);
		end
	end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/100ps
`include "mipsCore_consts.svh"

module registerFile (
	input logic clk,
	input logic reset,
	input logic writeEn,
	input mipsCorePkg::regIdx_t writeIdx,
	input mipsCorePkg::word_t writeData,
	input mipsCorePkg::regIdx_t readIdxA,
	input mipsCorePkg::regIdx_t readIdxB,
	output mipsCorePkg::word_t readDataA,
	output mipsCorePkg::word_t readDataB,
	output mipsCorePkg::word_t registerV0
);
	import mipsCorePkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeIdx != '0) begin
			regs[writeIdx] <= writeData;
		end
	end

	// $zero is hardwired on the read side
	assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];
	assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];

	assign registerV0 = regs[`V0_INDEX];

	// Enabled writes carry a known index and value
	assert property (@(posedge clk) disable iff (reset)
		writeEn |-> !$isunknown({writeIdx, writeData}))
		else $error("registerFile: write with an unknown index or value");

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
	input mipsCorePkg::ctrl_t ctrl,
	input mipsCorePkg::word_t rsData,
	input mipsCorePkg::word_t rtData,
	input mipsCorePkg::word_t immOperand,
	output mipsCorePkg::aluRes_t result
);
	import mipsCorePkg::*;

	word_t opB;
	logic lessSigned;
	logic lessUnsigned;

	// Second operand is the immediate for I-type and memory ops
	assign opB = ctrl.useImm ? immOperand : rtData;

	assign lessSigned = $signed(rsData) < $signed(opB);
	assign lessUnsigned = rsData < opB;

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD: result.value = rsData + opB;
			ALU_SUB: result.value = rsData - opB;
			ALU_AND: result.value = rsData & opB;
			ALU_OR: result.value = rsData | opB;
			ALU_XOR: result.value = rsData ^ opB;
			ALU_SLT: result.value = {31'b0, lessSigned};
			ALU_SLTU: result.value = {31'b0, lessUnsigned};
			// Shifts always act on rt
			ALU_SLL: result.value = rtData << ctrl.shamt;
			ALU_SRL: result.value = rtData >> ctrl.shamt;
			// Decoder has already moved the immediate to the upper half
			ALU_LUI: result.value = immOperand;
			default: result.value = '0;
		endcase
	end

	// Branch compare is always rs against rt
	assign result.eq = (rsData == rtData);

endmodule

// File: rtl/nextPcUnit.sv
`timescale 1ns/100ps

module nextPcUnit (
	input mipsCorePkg::ctrl_t ctrl,
	input mipsCorePkg::word_t pc,
	input mipsIsaPkg::instrIndex_t instrIndex,
	input mipsIsaPkg::imm16_t offset,
	input mipsCorePkg::word_t rsData,
	input logic eq,
	output mipsCorePkg::word_t nextPc,
	output mipsCorePkg::word_t returnAddr
);
	import mipsCorePkg::*;

	word_t pcPlus4;
	word_t branchTarget;
	word_t jumpTarget;
	logic branchTaken;

	assign pcPlus4 = pc + 32'd4;

	// Word offset relative to the following instruction
	assign branchTarget = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};

	// Region bits come from PC+4
	assign jumpTarget = {pcPlus4[31:28], instrIndex, 2'b00};

	assign branchTaken = (ctrl.branchEq && eq) || (ctrl.branchNe && !eq);

	always_comb begin
		if (ctrl.jumpReg) begin
			nextPc = rsData;
		end else if (ctrl.jump) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	// Link value keeps the MIPS PC+8 convention
	assign returnAddr = pc + 32'd8;

endmodule

// File: rtl/commitStage.sv
`timescale 1ns/100ps
`include "mipsCore_consts.svh"

module commitStage (
	input logic clk,
	input logic reset,
	input logic clkEnable,
	input mipsCorePkg::ctrl_t ctrl,
	input mipsCorePkg::word_t nextPc,
	input mipsCorePkg::word_t aluResult,
	input mipsCorePkg::word_t memData,
	input mipsCorePkg::word_t returnAddr,
	output mipsCorePkg::word_t pc,
	output logic active,
	output logic writeEn,
	output mipsCorePkg::word_t writeData
);
	import mipsCorePkg::*;

	logic advance;

	// State only moves on enabled cycles of a running core
	assign advance = clkEnable && active;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_VECTOR;
			active <= 1'b1;
		end else if (advance) begin
			pc <= nextPc;
			// Jumping to address zero ends the program
			if (nextPc == '0) begin
				active <= 1'b0;
			end
		end
	end

	always_comb begin
		if (ctrl.memRead) begin
			writeData = memData;
		end else if (ctrl.link) begin
			writeData = returnAddr;
		end else begin
			writeData = aluResult;
		end
	end

	assign writeEn = ctrl.regWrite && advance;

	// A running core fetches only word-aligned addresses
	assert property (@(posedge clk) disable iff (reset) active |-> pc[1:0] == 2'b00)
		else $error("commitStage: PC %h is not word aligned", pc);

endmodule

// File: rtl/mipsCpuHarvard.sv
`timescale 1ns/100ps

module mipsCpuHarvard (
	input logic clk,
	input logic reset,
	output logic active,
	output mipsCorePkg::word_t registerV0,
	input logic clkEnable,
	output mipsCorePkg::word_t instrAddress,
	input mipsCorePkg::word_t instrReaddata,
	output mipsCorePkg::word_t dataAddress,
	output logic dataWrite,
	output logic dataRead,
	output mipsCorePkg::word_t dataWritedata,
	input mipsCorePkg::word_t dataReaddata
);
	import mipsCorePkg::*;

	ctrl_t ctrl;
	word_t immOperand;
	word_t rsData;
	word_t rtData;
	aluRes_t aluRes;
	word_t nextPc;
	word_t returnAddr;
	logic writeEn;
	word_t writeData;

	controlDecoder decoder0 (.instr(instrReaddata), .ctrl(ctrl), .immOperand(immOperand));

	registerFile regFile0 (
		.clk(clk), .reset(reset), .writeEn(writeEn), .writeIdx(ctrl.writeReg),
		.writeData(writeData), .readIdxA(instrReaddata[25:21]),
		.readIdxB(instrReaddata[20:16]), .readDataA(rsData), .readDataB(rtData),
		.registerV0(registerV0)
	);

	aluUnit alu0 (
		.ctrl(ctrl), .rsData(rsData), .rtData(rtData), .immOperand(immOperand),
		.result(aluRes)
	);

	nextPcUnit nextPc0 (
		.ctrl(ctrl), .pc(instrAddress), .instrIndex(instrReaddata[25:0]),
		.offset(instrReaddata[15:0]), .rsData(rsData), .eq(aluRes.eq),
		.nextPc(nextPc), .returnAddr(returnAddr)
	);

	commitStage commit0 (
		.clk(clk), .reset(reset), .clkEnable(clkEnable), .ctrl(ctrl), .nextPc(nextPc),
		.aluResult(aluRes.value), .memData(dataReaddata), .returnAddr(returnAddr),
		.pc(instrAddress), .active(active), .writeEn(writeEn), .writeData(writeData)
	);

	// Data bus address from the ALU and store data from rt
	assign dataAddress = aluRes.value;
	assign dataWritedata = rtData;
	assign dataWrite = ctrl.memWrite && clkEnable && active && !reset;
	assign dataRead = ctrl.memRead && active && !reset;

endmodule

// File: verif/mipsCpuChecker.sv
`timescale 1ns/100ps
`include "mipsCore_consts.svh"

module mipsCpuChecker (
	input logic clk,
	input logic reset,
	input logic clkEnable,
	input logic active,
	input logic dataWrite,
	input logic dataRead,
	input mipsCorePkg::word_t dataAddress,
	input mipsCorePkg::word_t dataWritedata,
	input mipsCorePkg::word_t registerV0
);
	import mipsCorePkg::*;

	word_t expAddr[$];
	word_t expData[$];
	word_t expV0;
	word_t wantAddr;
	word_t wantData;
	int errors;
	bit v0Checked;
	logic wasActive;

	function automatic void compareValue(string name, word_t want, word_t got);
		if (want !== got) begin
			$display("error at %0t ns: %s expected %h, got %h", $time, name, want, got);
			errors++;
		end
	endfunction

	task automatic beginTest();
		expAddr.delete();
		expData.delete();
		expV0 = '0;
		errors = 0;
		v0Checked = 0;
	endtask

	task automatic expectStore(word_t addr, word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic expectV0(word_t value);
		expV0 = value;
	endtask

	task automatic finishTest(output int errs);
		if (expAddr.size() != 0) begin
			$display("%0d expected stores never appeared on the data bus", expAddr.size());
			errors++;
		end
		if (!v0Checked) begin
			$display("the core never halted, so register v0 was not checked");
			errors++;
		end
		errs = errors;
	endtask

	// Stores commit on this edge, so the bus is sampled here
	always @(posedge clk) begin
		if (reset) begin
			wasActive <= 1'b1;
			if (dataWrite || dataRead) begin
				$display("a data strobe was high while reset was held");
				errors++;
			end
		end else begin
			if (dataWrite && dataRead) begin
				$display("dataWrite and dataRead were high together at %h", dataAddress);
				errors++;
			end
			if (dataWrite) begin
				if (!clkEnable) begin
					$display("store to %h appeared while clkEnable was low", dataAddress);
					errors++;
				end
				if (expAddr.size() == 0) begin
					$display("unexpected store of %h to %h", dataWritedata, dataAddress);
					errors++;
				end else begin
					wantAddr = expAddr.pop_front();
					wantData = expData.pop_front();
					compareValue("dataAddress", wantAddr, dataAddress);
					compareValue("dataWritedata", wantData, dataWritedata);
				end
			end
			// First edge after the halt
			if (wasActive && !active) begin
				compareValue($sformatf("registerV0 (r%0d)", `V0_INDEX), expV0, registerV0);
				v0Checked = 1;
			end
			wasActive <= active;
		end
	end

endmodule

// File: verif/mipsCpuTb.sv
`timescale 1ns/100ps
`include "mipsCore_consts.svh"

module mipsCpuTb;
	import mipsCorePkg::*;

	logic clk;
	logic reset;
	logic clkEnable;
	logic active;
	word_t registerV0;
	word_t instrAddress;
	word_t instrReaddata;
	word_t dataAddress;
	logic dataWrite;
	logic dataRead;
	word_t dataWritedata;
	word_t dataReaddata;

	word_t instrMem[word_t];
	word_t dataMem[word_t];
	logic storePending;
	word_t storeAddr;
	word_t storeData;

	int fd;
	string testName;
	bit stallTest;
	int testsRun;
	int testsFailed;
	bit timedOut;

	mipsCpuHarvard dut0 (
		.clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
		.clkEnable(clkEnable), .instrAddress(instrAddress), .instrReaddata(instrReaddata),
		.dataAddress(dataAddress), .dataWrite(dataWrite), .dataRead(dataRead),
		.dataWritedata(dataWritedata), .dataReaddata(dataReaddata)
	);

	mipsCpuChecker checker0 (
		.clk(clk), .reset(reset), .clkEnable(clkEnable), .active(active),
		.dataWrite(dataWrite), .dataRead(dataRead), .dataAddress(dataAddress),
		.dataWritedata(dataWritedata), .registerV0(registerV0)
	);

	always #2 clk = ~clk;

	// Outside the program the fetch sees a NOP
	always_comb begin
		if (instrMem.exists(instrAddress)) begin
			instrReaddata = instrMem[instrAddress];
		end else begin
			instrReaddata = '0;
		end
	end

	always_comb begin
		if (dataRead !== 1'b1) begin
			// Without a read strobe the bus returns nothing
			dataReaddata = '0;
		end else if (dataMem.exists(dataAddress)) begin
			dataReaddata = dataMem[dataAddress];
		end else begin
			dataReaddata = dataAddress ^ 32'h5A5A_C3C3;
		end
	end

	// Store captured at the edge and written into memory half a cycle later
	always @(posedge clk) begin
		storePending <= dataWrite;
		storeAddr <= dataAddress;
		storeData <= dataWritedata;
	end

	always @(negedge clk) begin
		if (storePending === 1'b1) begin
			dataMem[storeAddr] = storeData;
		end
	end

	function automatic string nextToken();
		string tok;
		string rest;
		int r;
		tok = "";
		r = $fscanf(fd, "%s", tok);
		while (r == 1 && tok.substr(0, 0) == "#") begin
			r = $fgets(rest, fd);
			r = $fscanf(fd, "%s", tok);
		end
		if (r != 1) begin
			tok = "";
		end
		return tok;
	endfunction

	function automatic word_t readHex();
		word_t value;
		int r;
		value = '0;
		r = $fscanf(fd, "%h", value);
		return value;
	endfunction

	task automatic readTest(output bit have, output bit ok);
		string tok;
		int n;
		int r;
		word_t addr;
		word_t value;
		have = 0;
		ok = 1;
		tok = nextToken();
		if (tok != "") begin
			have = 1;
			ok = (tok == "test");
			r = $fscanf(fd, "%s", testName);
			stallTest = (readHex() != 0);
			instrMem.delete();
			dataMem.delete();
			checker0.beginTest();
			ok = ok && (nextToken() == "prog");
			n = readHex();
			for (int i = 0; i < n; i++) begin
				instrMem[`RESET_VECTOR + 4 * i] = readHex();
			end
			ok = ok && (nextToken() == "data");
			n = readHex();
			for (int i = 0; i < n; i++) begin
				addr = readHex();
				dataMem[addr] = readHex();
			end
			ok = ok && (nextToken() == "store");
			n = readHex();
			for (int i = 0; i < n; i++) begin
				addr = readHex();
				value = readHex();
				checker0.expectStore(addr, value);
			end
			ok = ok && (nextToken() == "v0");
			checker0.expectV0(readHex());
		end
	endtask

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		clkEnable = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	endtask

	task automatic waitHalt(output bit halted);
		int cycles;
		cycles = 0;
		halted = 0;
		while (!halted && cycles < 2000) begin
			@(negedge clk);
			clkEnable = stallTest ? (($urandom % 3) != 0) : 1'b1;
			halted = !active;
			cycles++;
		end
		// Give the checker the edge on which it sees the halt
		if (halted) begin
			@(posedge clk);
			@(negedge clk);
		end
	endtask

	initial begin
		bit haveTest;
		bit parseOk;
		bit halted;
		bit done;
		int errs;
		clk = 1'b0;
		reset = 1'b1;
		clkEnable = 1'b1;
		void'($urandom(32'hf8abab34));
		testsRun = 0;
		testsFailed = 0;
		timedOut = 0;
		done = 0;
		fd = $fopen("verif/mipsCpu_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file");
			testsFailed++;
			done = 1;
		end
		while (!done) begin
			readTest(haveTest, parseOk);
			if (!haveTest) begin
				done = 1;
			end else if (!parseOk) begin
				$display("trace file is malformed in test %s", testName);
				testsFailed++;
				done = 1;
			end else begin
				applyReset();
				waitHalt(halted);
				testsRun++;
				if (!halted) begin
					$display("test %s: active never fell within 2000 cycles", testName);
					testsFailed++;
					timedOut = 1;
					done = 1;
				end else begin
					checker0.finishTest(errs);
					if (errs != 0) begin
						testsFailed++;
						$display("test %s: failed with %0d errors", testName, errs);
					end else begin
						$display("test %s: passed", testName);
					end
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("tests run %0d, passed %0d, failed %0d", testsRun, testsRun - testsFailed,
			testsFailed);
		if (testsFailed == 0 && testsRun > 0 && !timedOut) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verif/mipsCpu_trace.txt
# test <name> <stall>, prog <count> <words from reset vector>, data <count> <addr word>...
# store <count> <addr word>... in program order, v0 <final value>; all numbers hex
test arith 0
prog 1b
24080013 2409FFF0 01095021 01095823 01096024 01096825 01097026 0128782A 0128802B
AC0A0100 AC0B0104 AC0C0108 AC0D010C AC0E0110 AC0F0114 AC100118
313100FF 35128000 3933FFFF 2D140014 3C151234
AC11011C AC120120 AC130124 AC140128 02A81021 00000008
data 0
store b
100 00000003 104 00000023 108 00000010 10C FFFFFFF3 110 FFFFFFE3 114 00000001
118 00000000 11C 000000F0 120 00008013 124 FFFF000F 128 00000001
v0 12340013
# shifts, loads, stores and writes to register zero
test shiftMem 0
prog d
8C080200 8C090204 00085100 00085FC2 00096102 25200005
AC000300 AC0A0304 AC0B0308 AC0C030C AC090200 8C020200 00000008
data 2
200 80000001 204 000000F0
store 5
300 00000000 304 00000010 308 00000001 30C 0000000F 200 000000F0
v0 000000F0
# branches, jumps and a subroutine call
test branchJump 0
prog 11
24080001 24090001 11090002 24020BAD AC0803FC 15090001 0FF0000B 240A0077 AC1F0400
AC0A0404 00000008 24020055 14400001 24020BAD 0BF00010 24020BAD 03E00008
data 0
store 2
400 BFC00020 404 00000000
v0 00000055
# same as shiftMem with clkEnable dropped in random cycles
test shiftMemStall 1
prog d
8C080200 8C090204 00085100 00085FC2 00096102 25200005
AC000300 AC0A0304 AC0B0308 AC0C030C AC090200 8C020200 00000008
data 2
200 80000001 204 000000F0
store 5
300 00000000 304 00000010 308 00000001 30C 0000000F 200 000000F0
v0 000000F0

// File: mipsCpu.f
+incdir+rtl
rtl/mipsIsaPkg.sv
rtl/mipsCorePkg.sv
rtl/controlDecoder.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/nextPcUnit.sv
rtl/commitStage.sv
rtl/mipsCpuHarvard.sv
verif/mipsCpuChecker.sv
verif/mipsCpuTb.sv

// File: Makefile
SIM      := verilator
VFLAGS   := --binary -Wno-fatal
TOP      := mipsCpuTb
FILELIST := mipsCpu.f
OBJDIR   := obj_dir

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) rtl/mipsCore_consts.svh
TRACE    := verif/mipsCpu_trace.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN) $(TRACE)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
